// ==== Bender.yml ====
package:
  name: sparhixcel

sources:
  - source/sa_pkg.sv
  - source/dram_pkg.sv
  - source/dram_access_ctrl.sv
  - source/dram_to_memory.sv
  - source/feature_memory.sv
  - source/sa_controller.sv
  - source/systolic_array.sv
  - source/sparhixcel_top.sv
  - target: simulation
    files:
      - bench/sparhixcel_props.sv
      - bench/tb_sparhixcel.sv

// ==== bench/sparhixcel_props.sv ====
`timescale 1ns/1ns

module sparhixcel_props (
    input logic clk_i,
    input logic rd_weight_rst,
    input logic busy_i,
    input logic done_i,
    input logic result_valid_i,
    input logic dram_rd_en_i
);

    // done is a single-cycle pulse
    done_one_cycle: assert property (
        @(posedge clk_i) disable iff (rd_weight_rst) done_i |=> !done_i
    ) else $error("done_o held high for a second cycle");

    result_in_job: assert property (
        @(posedge clk_i) disable iff (rd_weight_rst) result_valid_i |-> busy_i
    ) else $error("result_valid_o high outside a job");

    // reads only happen inside a job
    read_in_job: assert property (
        @(posedge clk_i) disable iff (rd_weight_rst) dram_rd_en_i |-> busy_i
    ) else $error("dram_rd_en_o high outside a job");

endmodule

// ==== bench/tb_sparhixcel.sv ====
`timescale 1ns/1ns

module tb_sparhixcel;
    import sa_pkg::*;
    import dram_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int TIMEOUT    = 200;
    localparam int DRAM_WORDS = 4096;
    localparam int N_RANDOM   = 12;
    localparam int EXT_BASE   = 4000;

    logic       clk_i;
    logic       rd_weight_rst;
    logic       start_i;
    job_cfg_t   cfg_i;
    dram_word_t mem_data_i;
    dram_addr_t dram_rd_address_o;
    logic       dram_rd_en_o;
    acc_t       result_o;
    logic       result_valid_o;
    logic       busy_o;
    logic       done_o;

    dram_word_t dram_mem [0:DRAM_WORDS-1];
    acc_t       exp_q [$];
    dram_addr_t addr_q [$];
    int         res_cnt;
    int         done_cnt;
    int         check_cnt;
    int         err_cnt;
    int         proto_cnt;
    logic       done_prev;

    sparhixcel_top dut0 (.*);

    // single instance of the top level, which is dut0
    bind sparhixcel_top sparhixcel_props props0 (
        .clk_i          (clk_i),
        .rd_weight_rst  (rd_weight_rst),
        .busy_i         (busy_o),
        .done_i         (done_o),
        .result_valid_i (result_valid_o),
        .dram_rd_en_i   (dram_rd_en_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    ////////////////////
    // DRAM model, one cycle read latency
    always @(posedge clk_i) begin
        if (dram_rd_en_o) begin
            mem_data_i <= dram_mem[dram_rd_address_o];
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL %s got 0x%h expected 0x%h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic report_error(input string msg);
        proto_cnt++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    task automatic finish_run();
        $display("checks %0d, value mismatches %0d, other errors %0d",
                 check_cnt, err_cnt, proto_cnt);
        if (err_cnt == 0 && proto_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    // four lanes per DRAM word, lane 0 in the low byte of the low word
    function automatic acc_t row_dot(input int wbase, input int fbase);
        int         sum;
        int         w;
        int         f;
        dram_word_t ww;
        dram_word_t fw;
        sum = 0;
        for (int i = 0; i < N_LANES; i++) begin
            ww  = dram_mem[wbase + i / 4];
            fw  = dram_mem[fbase + i / 4];
            w   = $signed(ww[8 * (i % 4) +: 8]);
            f   = $signed(fw[8 * (i % 4) +: 8]);
            sum = sum + w * f;
        end
        return acc_t'(sum);
    endfunction

    ////////////////////
    // monitors
    always @(posedge clk_i) begin
        if (!rd_weight_rst && result_valid_o) begin
            res_cnt++;
            if (exp_q.size() == 0) begin
                report_error("result_valid_o high with no row pending");
            end else begin
                check_value("result_o", result_o, exp_q.pop_front());
            end
        end
    end

    always @(posedge clk_i) begin
        if (!rd_weight_rst) begin
            if (dram_rd_en_o) begin
                if (addr_q.size() == 0) begin
                    report_error("DRAM read with no word expected");
                end else begin
                    check_value("dram_rd_address_o", dram_rd_address_o, addr_q.pop_front());
                end
            end
            if (done_o) begin
                done_cnt++;
            end
            if (done_o && done_prev) begin
                report_error("done_o high for two cycles");
            end
            if ((dram_rd_en_o || result_valid_o) && !busy_o) begin
                report_error("DRAM read or result while busy_o is low");
            end
            done_prev = done_o;
        end
    end

    task automatic run_job(input dram_addr_t wbase, input dram_addr_t fbase,
                           input int last_row, input bit poke);
        job_cfg_t cfg;
        int       cycles;
        int       res_before;
        int       done_before;
        cfg.weight_base  = wbase;
        cfg.feature_base = fbase;
        cfg.last_row     = FEAT_ADDR_WIDTH'(last_row);
        // weight row words, then every feature word in ascending order
        for (int k = 0; k < WORDS_PER_ROW; k++) begin
            addr_q.push_back(wbase + k);
        end
        for (int k = 0; k < (last_row + 1) * WORDS_PER_ROW; k++) begin
            addr_q.push_back(fbase + k);
        end
        for (int r = 0; r <= last_row; r++) begin
            exp_q.push_back(row_dot(wbase, fbase + r * WORDS_PER_ROW));
        end
        res_before  = res_cnt;
        done_before = done_cnt;
        @(posedge clk_i);
        start_i <= 1'b1;
        cfg_i   <= cfg;
        @(posedge clk_i);
        start_i <= 1'b0;
        cycles = 0;
        while (!busy_o && cycles < TIMEOUT) begin
            @(posedge clk_i);
            cycles++;
        end
        if (!busy_o) begin
            report_error("timeout waiting for busy_o after start");
            finish_run();
        end
        if (poke) begin
            // a second start mid-job must be dropped
            repeat (2) @(posedge clk_i);
            start_i <= 1'b1;
            cfg_i   <= ~cfg;
            @(posedge clk_i);
            start_i <= 1'b0;
        end
        cycles = 0;
        while (!done_o && cycles < TIMEOUT) begin
            @(posedge clk_i);
            cycles++;
        end
        if (!done_o) begin
            report_error("timeout waiting for done_o");
            finish_run();
        end
        @(posedge clk_i);
        check_value("result_valid_o count", res_cnt - res_before, last_row + 1);
        check_value("done_o pulses", done_cnt - done_before, 1);
        check_value("busy_o", busy_o, 1'b0);
        if (exp_q.size() != 0 || addr_q.size() != 0) begin
            report_error("job ended with results or DRAM reads still outstanding");
        end
    endtask

    initial begin
        dram_addr_t wbase;
        dram_addr_t fbase;
        void'($urandom(45297));
        rd_weight_rst = 1'b1;
        start_i       = 1'b0;
        cfg_i         = '0;
        mem_data_i    = '0;
        res_cnt       = 0;
        done_cnt      = 0;
        check_cnt     = 0;
        err_cnt       = 0;
        proto_cnt     = 0;
        done_prev     = 1'b0;
        for (int a = 0; a < DRAM_WORDS; a++) begin
            dram_mem[a] = $urandom;
        end
        repeat (2) @(posedge clk_i);
        rd_weight_rst <= 1'b0;

        // quiet after reset
        repeat (16) begin
            @(posedge clk_i);
            check_value("busy_o", busy_o, 1'b0);
            check_value("done_o", done_o, 1'b0);
            check_value("result_valid_o", result_valid_o, 1'b0);
            check_value("dram_rd_en_o", dram_rd_en_o, 1'b0);
        end

        ////////////////////
        // extreme values
        for (int k = 0; k < 4; k++) begin
            dram_mem[EXT_BASE + k] = 32'h8080_8080;
        end
        dram_mem[EXT_BASE + 4] = 32'h807f_807f;
        dram_mem[EXT_BASE + 5] = 32'h807f_807f;
        dram_mem[EXT_BASE + 6] = 32'h7f80_7f80;
        dram_mem[EXT_BASE + 7] = 32'h7f80_7f80;
        check_value("row_dot max", row_dot(EXT_BASE, EXT_BASE + 2), 32'sd131072);
        run_job(EXT_BASE, EXT_BASE + 2, 0, 1'b0);
        run_job(EXT_BASE + 4, EXT_BASE + 6, 0, 1'b0);
        run_job(EXT_BASE + 4, EXT_BASE + 4, 0, 1'b0);

        // same features, new weight row
        fbase = dram_addr_t'($urandom_range(0, 1000));
        run_job(dram_addr_t'(2000), fbase, 3, 1'b0);
        run_job(dram_addr_t'(2100), fbase, 3, 1'b0);

        ////////////////////
        // random jobs, some with a start while busy
        for (int j = 0; j < N_RANDOM; j++) begin
            wbase = dram_addr_t'($urandom_range(0, DRAM_WORDS - WORDS_PER_ROW));
            fbase = dram_addr_t'($urandom_range(0, DRAM_WORDS - FEAT_DEPTH * WORDS_PER_ROW));
            run_job(wbase, fbase, $urandom_range(0, FEAT_DEPTH - 1), (j % 3) == 1);
        end

        finish_run();
    end

endmodule

// ==== compile.f ====
source/sa_pkg.sv
source/dram_pkg.sv
source/dram_access_ctrl.sv
source/dram_to_memory.sv
source/feature_memory.sv
source/sa_controller.sv
source/systolic_array.sv
source/sparhixcel_top.sv
bench/sparhixcel_props.sv
bench/tb_sparhixcel.sv

// ==== source/dram_access_ctrl.sv ====
`timescale 1ns/1ns

module dram_access_ctrl (
    input  logic                  clk_i,
    input  logic                  rd_weight_rst,
    input  dram_pkg::fetch_req_t  fetch_req_i,
    output dram_pkg::dram_addr_t  dram_rd_address_o,
    output logic                  dram_rd_en_o,
    output logic                  word_valid_o,
    output dram_pkg::fetch_kind_e word_kind_o,
    output logic                  fetch_done_o
);
    import dram_pkg::*;

    dram_state_e               state_q;
    dram_addr_t                addr_q;
    logic [WORD_CNT_WIDTH-1:0] word_cnt_q;
    logic [WORD_CNT_WIDTH-1:0] last_word_q;
    fetch_kind_e               kind_q;
    logic                      word_valid_q;
    fetch_kind_e               word_kind_q;
    logic                      fetch_done_q;
    logic                      issue;
    logic                      final_word;
    logic                      accept;

    assign issue      = (state_q == ISSUE);
    assign final_word = issue && (word_cnt_q == last_word_q);

    // a request arriving with the final word chains onto the burst without a gap
    assign accept = fetch_req_i.valid && ((state_q == IDLE) || final_word);

    assign dram_rd_en_o      = issue;
    assign dram_rd_address_o = addr_q;
    assign word_valid_o      = word_valid_q;
    assign word_kind_o       = word_kind_q;
    assign fetch_done_o      = fetch_done_q;

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            state_q      <= IDLE;
            addr_q       <= '0;
            word_cnt_q   <= '0;
            last_word_q  <= '0;
            kind_q       <= FETCH_WEIGHTS;
            word_valid_q <= 1'b0;
            word_kind_q  <= FETCH_WEIGHTS;
            fetch_done_q <= 1'b0;
        end else begin
            // one-cycle read latency, so returning data follows the issue strobe
            word_valid_q <= issue;
            word_kind_q  <= kind_q;
            fetch_done_q <= (state_q == LAST);

            ////////////////////
            // address sequencing
            if (accept) begin
                state_q     <= ISSUE;
                addr_q      <= fetch_req_i.base;
                word_cnt_q  <= '0;
                last_word_q <= WORD_CNT_WIDTH'(fetch_req_i.last_row) * WORD_CNT_WIDTH'(WORDS_PER_ROW)
                               + WORD_CNT_WIDTH'(WORDS_PER_ROW - 1);
                kind_q      <= fetch_req_i.kind;
            end else begin
                case (state_q)
                    ISSUE: begin
                        addr_q     <= addr_q + 1'b1;
                        word_cnt_q <= word_cnt_q + 1'b1;
                        if (final_word) begin
                            state_q <= LAST;
                        end
                    end
                    // final word is on the bus now
                    LAST: state_q <= IDLE;
                    default: state_q <= IDLE;
                endcase
            end
        end
    end

endmodule

// ==== source/dram_pkg.sv ====
package dram_pkg;

    // read port
    localparam int DRAM_DATA_WIDTH = 32;
    localparam int DRAM_ADDR_WIDTH = sa_pkg::WORD_ADDR_WIDTH;

    // one array row spans this many DRAM words, low word first
    localparam int WORDS_PER_ROW  = sa_pkg::ROW_WIDTH / DRAM_DATA_WIDTH;
    localparam int WORD_SEL_WIDTH = $clog2(WORDS_PER_ROW);
    localparam int WORD_CNT_WIDTH = $clog2(sa_pkg::FEAT_DEPTH * WORDS_PER_ROW);

    typedef logic [DRAM_ADDR_WIDTH-1:0] dram_addr_t;
    typedef logic [DRAM_DATA_WIDTH-1:0] dram_word_t;

    typedef enum logic {
        FETCH_WEIGHTS,
        FETCH_FEATURES
    } fetch_kind_e;

    // valid is a single-cycle strobe
    typedef struct packed {
        logic                              valid;
        fetch_kind_e                       kind;
        dram_addr_t                        base;
        logic [sa_pkg::FEAT_ADDR_WIDTH-1:0] last_row;
    } fetch_req_t;

    typedef enum logic [1:0] {IDLE, ISSUE, LAST} dram_state_e;

endpackage

// ==== source/dram_to_memory.sv ====
`timescale 1ns/1ns

module dram_to_memory (
    input  logic                               clk_i,
    input  logic                               rd_weight_rst,
    input  dram_pkg::dram_word_t               mem_data_i,
    input  logic                               word_valid_i,
    input  dram_pkg::fetch_kind_e              word_kind_i,
    output sa_pkg::row_t                       row_data_o,
    output logic                               weight_wr_o,
    output logic                               feature_wr_o,
    output logic [sa_pkg::FEAT_ADDR_WIDTH-1:0] feature_wr_addr_o
);
    import sa_pkg::*;
    import dram_pkg::*;

    logic [ROW_WIDTH-1:0]       row_q;
    logic [WORD_SEL_WIDTH-1:0]  word_sel_q;
    logic                       row_done;
    logic                       weight_wr_q;
    logic                       feature_wr_q;
    logic [FEAT_ADDR_WIDTH-1:0] feat_addr_q;

    assign row_done = word_valid_i && (word_sel_q == WORD_SEL_WIDTH'(WORDS_PER_ROW - 1));

    assign row_data_o        = row_q;
    assign weight_wr_o       = weight_wr_q;
    assign feature_wr_o      = feature_wr_q;
    assign feature_wr_addr_o = feat_addr_q;

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            row_q        <= '0;
            word_sel_q   <= '0;
            weight_wr_q  <= 1'b0;
            feature_wr_q <= 1'b0;
            feat_addr_q  <= '0;
        end else begin
            weight_wr_q  <= row_done && (word_kind_i == FETCH_WEIGHTS);
            feature_wr_q <= row_done && (word_kind_i == FETCH_FEATURES);

            // new words enter at the top, first word ends up in lane 0
            if (word_valid_i) begin
                row_q      <= {mem_data_i, row_q[ROW_WIDTH-1:DRAM_DATA_WIDTH]};
                word_sel_q <= row_done ? '0 : word_sel_q + 1'b1;
            end

            // feature rows of a job start at address zero
            if (row_done && (word_kind_i == FETCH_WEIGHTS)) begin
                feat_addr_q <= '0;
            end else if (feature_wr_q) begin
                feat_addr_q <= feat_addr_q + 1'b1;
            end
        end
    end

endmodule

// ==== source/feature_memory.sv ====
`timescale 1ns/1ns

module feature_memory (
    input  logic                               clk_i,
    input  logic                               wr_en_i,
    input  logic [sa_pkg::FEAT_ADDR_WIDTH-1:0] wr_addr_i,
    input  sa_pkg::row_t                       wr_data_i,
    input  logic                               rd_en_i,
    input  logic [sa_pkg::FEAT_ADDR_WIDTH-1:0] rd_addr_i,
    output sa_pkg::row_t                       rd_data_o
);
    import sa_pkg::*;

    row_t mem [0:FEAT_DEPTH-1];
    row_t rd_data_q;

    // port a writes, port b reads with one cycle latency
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        if (rd_en_i) begin
            rd_data_q <= mem[rd_addr_i];
        end
    end

    // holds the last row while rd_en_i is low
    assign rd_data_o = rd_data_q;

endmodule

// ==== source/sa_controller.sv ====
`timescale 1ns/1ns

module sa_controller (
    input  logic                               clk_i,
    input  logic                               rd_weight_rst,
    input  logic                               start_i,
    input  sa_pkg::job_cfg_t                   cfg_i,
    input  logic                               fetch_done_i,
    output dram_pkg::fetch_req_t               fetch_req_o,
    output logic                               feat_rd_en_o,
    output logic [sa_pkg::FEAT_ADDR_WIDTH-1:0] feat_rd_addr_o,
    output logic                               row_valid_o,
    output logic                               busy_o,
    output logic                               done_o
);
    import sa_pkg::*;
    import dram_pkg::*;

    ctrl_state_e                state_q;
    job_cfg_t                   cfg_q;
    fetch_req_t                 fetch_req_q;
    logic [FEAT_ADDR_WIDTH-1:0] rd_addr_q;
    logic [1:0]                 tick_q;
    logic                       done_q;
    logic                       compute;

    assign compute = (state_q == COMPUTE);

    assign feat_rd_en_o   = compute;
    assign row_valid_o    = compute;
    assign feat_rd_addr_o = rd_addr_q;
    assign fetch_req_o    = fetch_req_q;
    // IDLE is declared in both packages
    assign busy_o         = (state_q != sa_pkg::IDLE);
    assign done_o         = done_q;

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            state_q     <= sa_pkg::IDLE;
            cfg_q       <= '0;
            fetch_req_q <= '0;
            rd_addr_q   <= '0;
            tick_q      <= '0;
            done_q      <= 1'b0;
        end else begin
            fetch_req_q.valid <= 1'b0;
            done_q            <= 1'b0;

            case (state_q)
                ////////////////////
                // fetch phase
                sa_pkg::IDLE: begin
                    if (start_i) begin
                        cfg_q       <= cfg_i;
                        fetch_req_q <= '{valid: 1'b1, kind: FETCH_WEIGHTS,
                                         base: cfg_i.weight_base, last_row: '0};
                        tick_q      <= '0;
                        state_q     <= FETCH_WEIGHT;
                    end
                end
                FETCH_WEIGHT: begin
                    // feature request meets the last weight word, no bus gap
                    if (tick_q == 2'(WORDS_PER_ROW - 1)) begin
                        fetch_req_q <= '{valid: 1'b1, kind: FETCH_FEATURES,
                                         base: cfg_q.feature_base, last_row: cfg_q.last_row};
                        state_q     <= FETCH_FEATURE;
                    end else begin
                        tick_q <= tick_q + 1'b1;
                    end
                end
                FETCH_FEATURE: begin
                    if (fetch_done_i) begin
                        rd_addr_q <= '0;
                        state_q   <= COMPUTE;
                    end
                end

                ////////////////////
                // compute phase
                COMPUTE: begin
                    rd_addr_q <= rd_addr_q + 1'b1;
                    if (rd_addr_q == cfg_q.last_row) begin
                        tick_q  <= '0;
                        state_q <= DRAIN;
                    end
                end
                DRAIN: begin
                    // last read plus the multiply and sum stages
                    tick_q <= tick_q + 1'b1;
                    if (tick_q == 2'(PIPE_TAIL)) begin
                        done_q  <= 1'b1;
                        state_q <= sa_pkg::IDLE;
                    end
                end
                default: state_q <= sa_pkg::IDLE;
            endcase
        end
    end

endmodule

// ==== source/sa_pkg.sv ====
package sa_pkg;

    // array geometry
    localparam int N_LANES   = 8;
    localparam int I_WIDTH   = 8;
    localparam int F_WIDTH   = 8;
    localparam int ROW_WIDTH = N_LANES * I_WIDTH;
    localparam int ACC_WIDTH = I_WIDTH + F_WIDTH + $clog2(N_LANES);

    // multiply and sum stages behind the memory read
    localparam int PIPE_TAIL = 2;

    // feature storage and job descriptor
    localparam int FEAT_DEPTH      = 16;
    localparam int FEAT_ADDR_WIDTH = $clog2(FEAT_DEPTH);
    localparam int WORD_ADDR_WIDTH = 18;

    typedef logic signed [I_WIDTH-1:0]   elem_t;
    typedef elem_t [N_LANES-1:0]         row_t;
    typedef logic signed [ACC_WIDTH-1:0] acc_t;

    // bases are DRAM word addresses, last_row is row count minus one
    typedef struct packed {
        logic [WORD_ADDR_WIDTH-1:0] weight_base;
        logic [WORD_ADDR_WIDTH-1:0] feature_base;
        logic [FEAT_ADDR_WIDTH-1:0] last_row;
    } job_cfg_t;

    typedef enum logic [2:0] {IDLE, FETCH_WEIGHT, FETCH_FEATURE, COMPUTE, DRAIN} ctrl_state_e;

endpackage

// ==== source/sparhixcel_top.sv ====
`timescale 1ns/1ns

module sparhixcel_top (
    input  logic                 clk_i,
    input  logic                 rd_weight_rst,
    input  logic                 start_i,
    input  sa_pkg::job_cfg_t     cfg_i,
    input  dram_pkg::dram_word_t mem_data_i,
    output dram_pkg::dram_addr_t dram_rd_address_o,
    output logic                 dram_rd_en_o,
    output sa_pkg::acc_t         result_o,
    output logic                 result_valid_o,
    output logic                 busy_o,
    output logic                 done_o
);
    import sa_pkg::*;
    import dram_pkg::*;

    fetch_req_t                 fetch_req;
    logic                       fetch_done;
    logic                       word_valid;
    fetch_kind_e                word_kind;
    row_t                       row_data;
    logic                       weight_wr;
    logic                       feature_wr;
    logic [FEAT_ADDR_WIDTH-1:0] feature_wr_addr;
    logic                       feat_rd_en;
    logic [FEAT_ADDR_WIDTH-1:0] feat_rd_addr;
    row_t                       feat_rd_data;
    logic                       row_valid;

    ////////////////////
    // job sequencing
    sa_controller control_block (
        .clk_i          (clk_i),
        .rd_weight_rst  (rd_weight_rst),
        .start_i        (start_i),
        .cfg_i          (cfg_i),
        .fetch_done_i   (fetch_done),
        .fetch_req_o    (fetch_req),
        .feat_rd_en_o   (feat_rd_en),
        .feat_rd_addr_o (feat_rd_addr),
        .row_valid_o    (row_valid),
        .busy_o         (busy_o),
        .done_o         (done_o)
    );

    ////////////////////
    // DRAM fetch path
    dram_access_ctrl dram_access_controller (
        .clk_i             (clk_i),
        .rd_weight_rst     (rd_weight_rst),
        .fetch_req_i       (fetch_req),
        .dram_rd_address_o (dram_rd_address_o),
        .dram_rd_en_o      (dram_rd_en_o),
        .word_valid_o      (word_valid),
        .word_kind_o       (word_kind),
        .fetch_done_o      (fetch_done)
    );

    dram_to_memory dram_to_mem (
        .clk_i             (clk_i),
        .rd_weight_rst     (rd_weight_rst),
        .mem_data_i        (mem_data_i),
        .word_valid_i      (word_valid),
        .word_kind_i       (word_kind),
        .row_data_o        (row_data),
        .weight_wr_o       (weight_wr),
        .feature_wr_o      (feature_wr),
        .feature_wr_addr_o (feature_wr_addr)
    );

    feature_memory feature_mem (
        .clk_i     (clk_i),
        .wr_en_i   (feature_wr),
        .wr_addr_i (feature_wr_addr),
        .wr_data_i (row_data),
        .rd_en_i   (feat_rd_en),
        .rd_addr_i (feat_rd_addr),
        .rd_data_o (feat_rd_data)
    );

    ////////////////////
    // compute
    systolic_array array_block (
        .clk_i          (clk_i),
        .rd_weight_rst  (rd_weight_rst),
        .weight_wr_i    (weight_wr),
        .weight_row_i   (row_data),
        .row_valid_i    (row_valid),
        .feature_row_i  (feat_rd_data),
        .result_o       (result_o),
        .result_valid_o (result_valid_o)
    );

endmodule

// ==== source/systolic_array.sv ====
`timescale 1ns/1ns

module systolic_array (
    input  logic         clk_i,
    input  logic         rd_weight_rst,
    input  logic         weight_wr_i,
    input  sa_pkg::row_t weight_row_i,
    input  logic         row_valid_i,
    input  sa_pkg::row_t feature_row_i,
    output sa_pkg::acc_t result_o,
    output logic         result_valid_o
);
    import sa_pkg::*;

    typedef logic signed [I_WIDTH+F_WIDTH-1:0] prod_t;

    row_t  weight_q;
    logic  row_live_q;
    prod_t prod_q [N_LANES];
    logic  prod_valid_q;
    acc_t  node [1:2*N_LANES-1];
    acc_t  result_q;
    logic  result_valid_q;

    ////////////////////
    // adder tree, leaves at N_LANES and up, root at node 1
    for (genvar i = 0; i < N_LANES; i++) begin : g_leaf
        assign node[N_LANES+i] = acc_t'(prod_q[i]);
    end

    for (genvar k = 1; k < N_LANES; k++) begin : g_node
        assign node[k] = node[2*k] + node[2*k+1];
    end

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            weight_q       <= '0;
            row_live_q     <= 1'b0;
            prod_valid_q   <= 1'b0;
            result_q       <= '0;
            result_valid_q <= 1'b0;
            for (int i = 0; i < N_LANES; i++) begin
                prod_q[i] <= '0;
            end
        end else begin
            if (weight_wr_i) begin
                weight_q <= weight_row_i;
            end

            // feature row arrives one cycle after row_valid_i
            row_live_q <= row_valid_i;

            // stage 1, lane products
            prod_valid_q <= row_live_q;
            if (row_live_q) begin
                for (int i = 0; i < N_LANES; i++) begin
                    prod_q[i] <= weight_q[i] * feature_row_i[i];
                end
            end

            // stage 2, row sum
            result_valid_q <= prod_valid_q;
            if (prod_valid_q) begin
                result_q <= node[1];
            end
        end
    end

    assign result_o       = result_q;
    assign result_valid_o = result_valid_q;

endmodule
